// File: flist.f
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/execute_unit.sv
src/mem_stage.sv
src/core_top.sv
verif/core_chk.sv
verif/core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -f flist.f --top-module core_tb -Mdir obj_dir -o core_tb
	./obj_dir/core_tb +verilator+error+limit+100 | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/core_tb.sv
`default_nettype none

module core_tb
  import rv_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] instr;
    logic        retires;
    reg_idx_t    rd;
    word_t       value;
  } entry_t;

  logic        clk;
  logic        reset_i;
  logic        imem_we_i;
  logic [7:0]  imem_addr_i;
  logic [31:0] imem_wdata_i;
  logic        wb_valid_o;
  reg_idx_t    wb_rd_o;
  word_t       wb_data_o;

  entry_t prog[$];
  entry_t expect_q[$];
  int     seed;
  int     value_errs;
  int     seq_errs;
  int     chk_errs;

  core_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(64)) i_core_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .imem_we_i    (imem_we_i),
    .imem_addr_i  (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  bind core_top core_chk i_core_chk (
    .clk            (clk),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_o),
    .x0_write_i     (id_q.valid && id_q.reg_w && (id_q.rd == '0)),
    .stall_i        (load_use_stall),
    .branch_taken_i (branch_taken),
    .if_valid_i     (if_q.valid),
    .id_valid_i     (id_q.valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // instruction encoders with operands in assembler order
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_sd(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3_dword, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic word_t sext_imm(int v);
    return {{52{v[11]}}, v[11:0]};
  endfunction

  task automatic push_instr(input logic [31:0] instr);
    entry_t e;
    e = '0;
    e.instr = instr;
    prog.push_back(e);
  endtask

  task automatic push_retire(input logic [31:0] instr, input int rd, input word_t value);
    entry_t e;
    e.instr   = instr;
    e.retires = 1'b1;
    e.rd      = rd[4:0];
    e.value   = value;
    prog.push_back(e);
  endtask

  task automatic build_program();
    int    r1;
    int    r2;
    int    sh1;
    int    sh2;
    word_t v;
    // dependent chain forwarding from both later stages
    push_retire(enc_i(opc_op_imm, f3_add_sub, 1, 0, 5), 1, 64'd5);
    push_retire(enc_i(opc_op_imm, f3_add_sub, 2, 1, 7), 2, 64'd12);
    push_retire(enc_r(f7_base, f3_add_sub, 3, 1, 2), 3, 64'd17);
    push_retire(enc_r(f7_alt, f3_add_sub, 4, 3, 1), 4, 64'd12);
    push_retire(enc_r(f7_base, f3_xor, 5, 4, 3), 5, 64'd29);
    push_retire(enc_r(f7_base, f3_or, 6, 5, 1), 6, 64'd29);
    push_retire(enc_r(f7_base, f3_and, 7, 6, 2), 7, 64'd12);
    push_retire(enc_r(f7_base, f3_slt, 8, 4, 3), 8, 64'd1);
    push_retire(enc_i(opc_op_imm, f3_add_sub, 9, 0, -8), 9, 64'hffff_ffff_ffff_fff8);
    push_retire(enc_r(f7_alt, f3_srl_sra, 10, 9, 8), 10, 64'hffff_ffff_ffff_fffc);
    push_retire(enc_r(f7_base, f3_srl_sra, 11, 9, 8), 11, 64'h7fff_ffff_ffff_fffc);
    push_retire(enc_r(f7_base, f3_sll, 12, 2, 8), 12, 64'd24);
    push_retire(enc_i(opc_op_imm, f3_and, 13, 9, 'hf0), 13, 64'hf0);
    push_retire(enc_i(opc_op_imm, f3_or, 14, 1, 'h100), 14, 64'h105);
    // store then load with the add right after the ld stalling once
    push_instr(enc_sd(3, 0, 16));
    push_retire(enc_i(opc_load, f3_dword, 15, 0, 16), 15, 64'd17);
    push_retire(enc_r(f7_base, f3_add_sub, 16, 15, 1), 16, 64'd22);
    push_instr(enc_sd(16, 0, 24));
    push_retire(enc_i(opc_load, f3_dword, 17, 0, 24), 17, 64'd22);
    // taken branches skip the two instructions after each
    push_instr(enc_b(f3_beq, 1, 1, 12));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 20, 0, 1));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 21, 0, 2));
    push_instr(enc_b(f3_bne, 1, 2, 12));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 20, 0, 1));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 21, 0, 2));
    push_instr(enc_b(f3_blt, 9, 1, 12));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 20, 0, 1));
    push_instr(enc_i(opc_op_imm, f3_add_sub, 21, 0, 2));
    // not taken
    push_instr(enc_b(f3_blt, 1, 9, 12));
    push_retire(enc_i(opc_op_imm, f3_add_sub, 22, 0, 3), 22, 64'd3);
    push_retire(enc_i(opc_op_imm, f3_add_sub, 23, 22, 4), 23, 64'd7);
    push_instr(enc_b(f3_bne, 1, 1, 12));
    push_retire(enc_i(opc_op_imm, f3_add_sub, 24, 23, 1), 24, 64'd8);
    // x0 is neither written nor forwarded
    push_instr(enc_i(opc_op_imm, f3_add_sub, 0, 1, 99));
    push_retire(enc_r(f7_base, f3_add_sub, 30, 0, 14), 30, 64'h105);
    for (int k = 0; k < 3; k++) begin
      r1  = $random(seed);
      r2  = $random(seed);
      sh1 = $random(seed) & 'h3f;
      sh2 = $random(seed) & 'h3f;
      v = sext_imm(r1);
      push_retire(enc_i(opc_op_imm, f3_add_sub, 25, 0, r1), 25, v);
      v = v ^ sext_imm(r2);
      push_retire(enc_i(opc_op_imm, f3_xor, 26, 25, r2), 26, v);
      v = v << sh1;
      push_retire(enc_i(opc_op_imm, f3_sll, 27, 26, sh1), 27, v);
      v = v >> sh2;
      push_retire(enc_i(opc_op_imm, f3_srl_sra, 28, 27, sh2), 28, v);
    end
    push_instr(enc_b(f3_beq, 0, 0, 0));
  endtask

  // word k lands two cycles before fetch reaches it
  // so loading may run past the 4 reset cycles
  task automatic load_program();
    for (int k = 0; k < prog.size(); k++) begin
      @(posedge clk);
      imem_we_i    <= 1'b1;
      imem_addr_i  <= k[7:0];
      imem_wdata_i <= prog[k].instr;
      if (k == 3) begin
        reset_i <= 1'b0;
      end
    end
    @(posedge clk);
    imem_we_i <= 1'b0;
  endtask

  task automatic check_retires(input int limit);
    int     cycles;
    int     drain;
    entry_t exp;
    cycles = 0;
    drain  = 0;
    @(negedge clk);
    while (reset_i) begin
      assert (wb_valid_o !== 1'b1) else begin
        $display("retirement seen during reset at %0t", $time);
        seq_errs++;
      end
      @(negedge clk);
    end
    // short drain after the self loop to catch late extras
    while (cycles < limit && drain < 10) begin
      if (wb_valid_o === 1'b1) begin
        if (expect_q.size() == 0) begin
          $display("extra retirement at %0t: x%0d after the last expected one", $time, wb_rd_o);
          seq_errs++;
        end else begin
          exp = expect_q.pop_front();
          assert (wb_rd_o == exp.rd) else begin
            $display("error: %0t wb_rd_o expected %0d got %0d", $time, exp.rd, wb_rd_o);
            value_errs++;
          end
          assert (wb_data_o == exp.value) else begin
            $display("error: %0t wb_data_o expected %h got %h", $time, exp.value, wb_data_o);
            value_errs++;
          end
        end
      end
      if (expect_q.size() == 0) begin
        drain++;
      end
      @(negedge clk);
      cycles++;
    end
    if (expect_q.size() != 0) begin
      $display("timeout after %0d cycles, %0d retirements never came", cycles, expect_q.size());
      seq_errs++;
    end
  endtask

  initial begin
    int limit;
    reset_i      = 1'b1;
    imem_we_i    = 1'b0;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    seed         = 32'h76abb8d7;
    value_errs   = 0;
    seq_errs     = 0;
    build_program();
    for (int k = 0; k < prog.size(); k++) begin
      if (prog[k].retires) begin
        expect_q.push_back(prog[k]);
      end
    end
    limit = 20 * prog.size() + 100;
    fork
      load_program();
      check_retires(limit);
    join
    chk_errs = i_core_top.i_core_chk.reset_fails + i_core_top.i_core_chk.x0_fails +
               i_core_top.i_core_chk.stall_fails + i_core_top.i_core_chk.flush_fails;
    $display("errors: %0d value, %0d sequence, %0d assertion", value_errs, seq_errs, chk_errs);
    if (value_errs == 0 && seq_errs == 0 && chk_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/core_chk.sv
`default_nettype none

module core_chk (
  input wire logic clk,
  input wire logic reset_i,
  input wire logic wb_valid_i,
  input wire logic x0_write_i,
  input wire logic stall_i,
  input wire logic branch_taken_i,
  input wire logic if_valid_i,
  input wire logic id_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // failure count per property
  int reset_fails = 0;
  int x0_fails    = 0;
  int stall_fails = 0;
  int flush_fails = 0;

  a_quiet_in_reset: assert property (@(posedge clk) reset_i |=> !wb_valid_i)
    else begin
      $error("retire port active during reset");
      reset_fails++;
    end

  // an x0 write in execute reaches writeback two cycles later
  a_no_x0_retire: assert property (@(posedge clk) disable iff (reset_i)
                                   x0_write_i |-> ##2 !wb_valid_i)
    else begin
      $error("retirement reported for a write to x0");
      x0_fails++;
    end

  // the bubble in ID/EX clears the hazard on the next cycle
  a_single_stall: assert property (@(posedge clk) disable iff (reset_i)
                                   stall_i |=> !stall_i)
    else begin
      $error("load-use stall longer than one cycle");
      stall_fails++;
    end

  a_branch_flush: assert property (@(posedge clk) disable iff (reset_i)
                                   branch_taken_i |=> !if_valid_i && !id_valid_i)
    else begin
      $error("younger stages still valid after a taken branch");
      flush_fails++;
    end

endmodule

`default_nettype wire

// File: src/core_top.sv
`default_nettype none

module core_top
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 64
) (
  input  wire logic                          clk,
  input  wire logic                          reset_i,
  input  wire logic                          imem_we_i,
  input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
  input  wire logic [31:0]                   imem_wdata_i,
  output logic                               wb_valid_o,
  output reg_idx_t                           wb_rd_o,
  output word_t                              wb_data_o
);

  if_id_t    if_d;
  if_id_t    if_q;
  id_ex_t    id_d;
  id_ex_t    id_q;
  ex_mem_t   ex_d;
  ex_mem_t   ex_q;
  mem_wb_t   mem_d;
  mem_wb_t   mem_q;

  reg_idx_t  dec_rs1;
  reg_idx_t  dec_rs2;
  reg_idx_t  dec_rd;
  word_t     dec_imm;
  instr_id_e dec_id;
  logic      dec_reg_w;
  logic      dec_mem_r;
  logic      dec_mem_w;
  logic      dec_branch;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      rf_we;

  logic      branch_taken;
  word_t     branch_target;
  logic      load_use_stall;

  // load in execute feeding the instruction in decode
  assign load_use_stall = id_q.valid && id_q.mem_r && (id_q.rd != '0) &&
                          ((id_q.rd == dec_rs1) || (id_q.rd == dec_rs2));

  fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch_unit (
    .clk             (clk),
    .reset_i         (reset_i),
    .hold_i          (load_use_stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .imem_we_i       (imem_we_i),
    .imem_addr_i     (imem_addr_i),
    .imem_wdata_i    (imem_wdata_i),
    .if_o            (if_d)
  );

  pipe_reg #(.payload_t(if_id_t)) i_if_id (
    .clk     (clk),
    .reset_i (reset_i),
    .en_i    (!load_use_stall),
    .flush_i (branch_taken),
    .d_i     (if_d),
    .q_o     (if_q)
  );

  decoder i_decoder (
    .instr_i    (if_q.instr),
    .rs1_o      (dec_rs1),
    .rs2_o      (dec_rs2),
    .rd_o       (dec_rd),
    .imm_o      (dec_imm),
    .instr_id_o (dec_id),
    .reg_w_o    (dec_reg_w),
    .mem_r_o    (dec_mem_r),
    .mem_w_o    (dec_mem_w),
    .branch_o   (dec_branch)
  );

  regfile i_regfile (
    .clk      (clk),
    .we_i     (rf_we),
    .waddr_i  (mem_q.rd),
    .wdata_i  (mem_q.data),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  always_comb begin
    id_d.valid    = if_q.valid;
    id_d.pc       = if_q.pc;
    id_d.rs1      = dec_rs1;
    id_d.rs2      = dec_rs2;
    id_d.rd       = dec_rd;
    id_d.rs1_val  = rf_rdata1;
    id_d.rs2_val  = rf_rdata2;
    id_d.imm      = dec_imm;
    id_d.instr_id = dec_id;
    id_d.reg_w    = dec_reg_w;
    id_d.mem_r    = dec_mem_r;
    id_d.mem_w    = dec_mem_w;
    id_d.branch   = dec_branch;
  end

  // bubble on a load-use stall
  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk     (clk),
    .reset_i (reset_i),
    .en_i    (1'b1),
    .flush_i (branch_taken || load_use_stall),
    .d_i     (id_d),
    .q_o     (id_q)
  );

  execute_unit i_execute_unit (
    .ex_i            (id_q),
    .mem_fwd_i       (ex_q),
    .wb_fwd_i        (mem_q),
    .ex_o            (ex_d),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk     (clk),
    .reset_i (reset_i),
    .en_i    (1'b1),
    .flush_i (1'b0),
    .d_i     (ex_d),
    .q_o     (ex_q)
  );

  mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_mem_stage (
    .clk   (clk),
    .mem_i (ex_q),
    .wb_o  (mem_d)
  );

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk     (clk),
    .reset_i (reset_i),
    .en_i    (1'b1),
    .flush_i (1'b0),
    .d_i     (mem_d),
    .q_o     (mem_q)
  );

  // writes to x0 neither update the regfile nor retire
  assign rf_we      = mem_q.valid && mem_q.reg_w && (mem_q.rd != '0);
  assign wb_valid_o = rf_we;
  assign wb_rd_o    = mem_q.rd;
  assign wb_data_o  = mem_q.data;

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`default_nettype none

module mem_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter int DMEM_DEPTH = 64
) (
  input  wire logic    clk,
  input  wire ex_mem_t mem_i,
  output mem_wb_t      wb_o
);

  localparam int aw = $clog2(DMEM_DEPTH);

  word_t         dmem [DMEM_DEPTH];
  logic [aw-1:0] idx;

  // doubleword index, upper address bits wrap
  assign idx = mem_i.alu_result[aw+2:3];

  always_ff @(posedge clk) begin
    if (mem_i.valid && mem_i.mem_w) begin
      dmem[idx] <= mem_i.store_data;
    end
  end

  always_comb begin
    wb_o.valid = mem_i.valid;
    wb_o.rd    = mem_i.rd;
    wb_o.reg_w = mem_i.reg_w;
    wb_o.data  = mem_i.mem_r ? dmem[idx] : mem_i.alu_result;
  end

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`default_nettype none

module execute_unit
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  wire id_ex_t  ex_i,
  input  wire ex_mem_t mem_fwd_i,
  input  wire mem_wb_t wb_fwd_i,
  output ex_mem_t      ex_o,
  output logic         branch_taken_o,
  output word_t        branch_target_o
);

  word_t op_a;
  word_t op_b;
  word_t alu_res;
  logic  cond;

  // memory stage first, then writeback, x0 never forwarded
  function automatic word_t fwd_sel(reg_idx_t idx, word_t rf_val,
                                    ex_mem_t m, mem_wb_t w);
    word_t val;
    val = rf_val;
    if (idx != '0) begin
      if (m.valid && m.reg_w && !m.mem_r && m.rd == idx) begin
        val = m.alu_result;
      end else if (w.valid && w.reg_w && w.rd == idx) begin
        val = w.data;
      end
    end
    return val;
  endfunction

  assign op_a = fwd_sel(ex_i.rs1, ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
  assign op_b = fwd_sel(ex_i.rs2, ex_i.rs2_val, mem_fwd_i, wb_fwd_i);

  always_comb begin
    case (ex_i.instr_id)
      i_add:   alu_res = op_a + op_b;
      i_sub:   alu_res = op_a - op_b;
      i_and:   alu_res = op_a & op_b;
      i_or:    alu_res = op_a | op_b;
      i_xor:   alu_res = op_a ^ op_b;
      i_slt:   alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
      i_sll:   alu_res = op_a << op_b[5:0];
      i_srl:   alu_res = op_a >> op_b[5:0];
      i_sra:   alu_res = word_t'($signed(op_a) >>> op_b[5:0]);
      i_addi:  alu_res = op_a + ex_i.imm;
      i_andi:  alu_res = op_a & ex_i.imm;
      i_ori:   alu_res = op_a | ex_i.imm;
      i_xori:  alu_res = op_a ^ ex_i.imm;
      i_slli:  alu_res = op_a << ex_i.imm[5:0];
      i_srli:  alu_res = op_a >> ex_i.imm[5:0];
      // effective address
      i_ld:    alu_res = op_a + ex_i.imm;
      i_sd:    alu_res = op_a + ex_i.imm;
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    case (ex_i.instr_id)
      i_beq:   cond = (op_a == op_b);
      i_bne:   cond = (op_a != op_b);
      i_blt:   cond = ($signed(op_a) < $signed(op_b));
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken_o  = ex_i.valid && ex_i.branch && cond;
  assign branch_target_o = ex_i.pc + ex_i.imm;

  always_comb begin
    ex_o.valid      = ex_i.valid;
    ex_o.rd         = ex_i.rd;
    ex_o.alu_result = alu_res;
    ex_o.store_data = op_b;
    ex_o.reg_w      = ex_i.reg_w;
    ex_o.mem_r      = ex_i.mem_r;
    ex_o.mem_w      = ex_i.mem_w;
  end

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile
  import rv_isa_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     we_i,
  input  wire reg_idx_t waddr_i,
  input  wire word_t    wdata_i,
  input  wire reg_idx_t raddr1_i,
  input  wire reg_idx_t raddr2_i,
  output word_t         rdata1_o,
  output word_t         rdata2_o
);

  // no storage for x0
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through, a same-cycle read sees the new value
  function automatic word_t read_port(reg_idx_t addr);
    word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (we_i && addr == waddr_i) begin
      val = wdata_i;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  assign rdata1_o = read_port(raddr1_i);
  assign rdata2_o = read_port(raddr2_i);

endmodule

`default_nettype wire

// File: src/decoder.sv
`default_nettype none

module decoder
  import rv_isa_pkg::*;
(
  input  wire logic [31:0] instr_i,
  output reg_idx_t         rs1_o,
  output reg_idx_t         rs2_o,
  output reg_idx_t         rd_o,
  output word_t            imm_o,
  output instr_id_e        instr_id_o,
  output logic             reg_w_o,
  output logic             mem_r_o,
  output logic             mem_w_o,
  output logic             branch_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       uses_rs2;
  instr_id_e  id;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    id    = i_nop;
    imm_o = '0;
    case (instr_i[6:0])
      opc_op: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add_sub: id = i_add;
            f3_sll:     id = i_sll;
            f3_slt:     id = i_slt;
            f3_xor:     id = i_xor;
            f3_srl_sra: id = i_srl;
            f3_or:      id = i_or;
            f3_and:     id = i_and;
            default:    id = i_nop;
          endcase
        end else if (funct7 == f7_alt && funct3 == f3_add_sub) begin
          id = i_sub;
        end else if (funct7 == f7_alt && funct3 == f3_srl_sra) begin
          id = i_sra;
        end
      end
      opc_op_imm: begin
        imm_o = {{52{instr_i[31]}}, instr_i[31:20]};
        case (funct3)
          f3_add_sub: id = i_addi;
          f3_xor:     id = i_xori;
          f3_or:      id = i_ori;
          f3_and:     id = i_andi;
          // rv64 shifts carry a 6-bit shamt, funct6 must be zero
          f3_sll:     id = (instr_i[31:26] == '0) ? i_slli : i_nop;
          f3_srl_sra: id = (instr_i[31:26] == '0) ? i_srli : i_nop;
          default:    id = i_nop;
        endcase
      end
      opc_load: begin
        imm_o = {{52{instr_i[31]}}, instr_i[31:20]};
        id    = (funct3 == f3_dword) ? i_ld : i_nop;
      end
      opc_store: begin
        imm_o = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        id    = (funct3 == f3_dword) ? i_sd : i_nop;
      end
      opc_branch: begin
        imm_o = {{51{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                 instr_i[11:8], 1'b0};
        case (funct3)
          f3_beq:  id = i_beq;
          f3_bne:  id = i_bne;
          f3_blt:  id = i_blt;
          default: id = i_nop;
        endcase
      end
      default: id = i_nop;
    endcase
  end

  assign mem_r_o  = (id == i_ld);
  assign mem_w_o  = (id == i_sd);
  assign branch_o = (id inside {i_beq, i_bne, i_blt});
  assign reg_w_o  = (id != i_nop) && !mem_w_o && !branch_o;
  assign uses_rs2 = (id inside {i_add, i_sub, i_and, i_or, i_xor, i_slt, i_sll, i_srl, i_sra})
                    || mem_w_o || branch_o;

  // unused fields read as x0 so they never match a hazard
  assign rs1_o      = (id == i_nop) ? '0 : instr_i[19:15];
  assign rs2_o      = uses_rs2 ? instr_i[24:20] : '0;
  assign rd_o       = reg_w_o ? instr_i[11:7] : '0;
  assign instr_id_o = id;

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none

module fetch_unit
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter int IMEM_DEPTH = 256
) (
  input  wire logic                          clk,
  input  wire logic                          reset_i,
  input  wire logic                          hold_i,
  input  wire logic                          branch_taken_i,
  input  wire word_t                         branch_target_i,
  input  wire logic                          imem_we_i,
  input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
  input  wire logic [31:0]                   imem_wdata_i,
  output if_id_t                             if_o
);

  localparam int aw = $clog2(IMEM_DEPTH);

  logic [31:0] imem [IMEM_DEPTH];
  word_t       pc_q;

  // branch wins over the load-use hold
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= '0;
    end else if (branch_taken_i) begin
      pc_q <= branch_target_i;
    end else if (!hold_i) begin
      pc_q <= pc_q + 'd4;
    end
  end

  // load port
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_wdata_i;
    end
  end

  always_comb begin
    if_o.valid = !reset_i;
    if_o.pc    = pc_q;
    if_o.instr = imem[pc_q[aw+1:2]];
  end

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset_i,
  input  wire logic     en_i,
  input  wire logic     flush_i,
  input  wire payload_t d_i,
  output payload_t      q_o
);

  // clearing the payload also drops its valid bit
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      q_o <= '0;
    end else if (en_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  typedef struct packed {
    logic        valid;
    word_t       pc;
    logic [31:0] instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    instr_id_e instr_id;
    logic      reg_w;
    logic      mem_r;
    logic      mem_w;
    logic      branch;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    alu_result;
    word_t    store_data;
    logic     reg_w;
    logic     mem_r;
    logic     mem_w;
  } ex_mem_t;

  // data already holds load data or alu result
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     reg_w;
    word_t    data;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011
  } opcode_e;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_dword   = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_blt     = 3'b100;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // i_nop is zero so a cleared stage decodes as a bubble
  typedef enum logic [4:0] {
    i_nop, i_add, i_sub, i_and, i_or, i_xor, i_slt, i_sll, i_srl, i_sra,
    i_addi, i_andi, i_ori, i_xori, i_slli, i_srli,
    i_ld, i_sd, i_beq, i_bne, i_blt
  } instr_id_e;

endpackage

`default_nettype wire
